/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_swan_video_out
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
WARN_FLAGS ?= -Wno-fatal
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) $(WARN_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(WARN_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* bench/tb_swan_video_out.sv */
module tb_swan_video_out;

  localparam int pix_div = 6;
  localparam int line_clocks = (swan_video_pkg::h_last + 1) * pix_div;
  localparam int active_clocks = swan_video_pkg::screen_w * pix_div;
  localparam int frame_samples = active_clocks * swan_video_pkg::screen_h;
  // About twelve frames, the tests need roughly five
  localparam int timeout_cycles = 8000000;

  logic                                  clk_sys_36_864 = 1'b0;
  logic                                  rst_n;
  logic                                  pixel_we;
  logic [swan_video_pkg::pix_addr_w-1:0] pixel_addr;
  swan_video_pkg::pixel_word_t           pixel_data;
  logic                                  triple_buffer;
  swan_video_pkg::blend_mode_t           blend_mode;
  logic                                  button_select;
  logic                                  ff_sound;
  logic [15:0]                           audio_in_l;
  logic [15:0]                           audio_in_r;
  logic                                  hsync;
  logic                                  vsync;
  logic                                  hblank;
  logic                                  vblank;
  logic [7:0]                            video_r;
  logic [7:0]                            video_g;
  logic [7:0]                            video_b;
  logic                                  ff_active;
  logic [15:0]                           audio_l;
  logic [15:0]                           audio_r;

  int cycle_cnt = 0;

  swan_video_out #(
    .ff_tap_cycles (50)
  ) i_swan_video_out (
    .clk_sys_36_864 (clk_sys_36_864),
    .rst_n          (rst_n),
    .pixel_we       (pixel_we),
    .pixel_addr     (pixel_addr),
    .pixel_data     (pixel_data),
    .triple_buffer  (triple_buffer),
    .blend_mode     (blend_mode),
    .button_select  (button_select),
    .ff_sound       (ff_sound),
    .audio_in_l     (audio_in_l),
    .audio_in_r     (audio_in_r),
    .hsync          (hsync),
    .vsync          (vsync),
    .hblank         (hblank),
    .vblank         (vblank),
    .video_r        (video_r),
    .video_g        (video_g),
    .video_b        (video_b),
    .ff_active      (ff_active),
    .audio_l        (audio_l),
    .audio_r        (audio_r)
  );

  always #5 clk_sys_36_864 = ~clk_sys_36_864;

  always @(posedge clk_sys_36_864) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: tests still running after %0d clock cycles", cycle_cnt);
      $display("Errors found");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("Errors found");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Nibble copied into both halves of the byte
  function automatic logic [7:0] level_single(input logic [3:0] n);
    return {n, n};
  endfunction

  function automatic logic [7:0] level_pair(input logic [3:0] now, input logic [3:0] prev);
    int s;
    s = int'(now) + int'(prev);
    return 8'((s << 3) | (s >> 2));
  endfunction

  // Six-bit sum stretched to a byte, then scaled by about 4/3
  function automatic logic [7:0] level_triple(input logic [3:0] a, input logic [3:0] b,
                                              input logic [3:0] c);
    int s;
    int lvl;
    s = int'(a) + int'(b) + int'(c);
    lvl = (s << 2) | (s >> 4);
    return 8'(lvl * swan_video_pkg::blend_mul / swan_video_pkg::blend_div);
  endfunction

  task automatic write_frame(input swan_video_pkg::pixel_word_t colour);
    for (int a = 0; a < swan_video_pkg::frame_pixels; a++) begin
      @(posedge clk_sys_36_864);
      pixel_we   <= 1'b1;
      pixel_addr <= swan_video_pkg::pix_addr_w'(a);
      pixel_data <= colour;
    end
    @(posedge clk_sys_36_864);
    pixel_we <= 1'b0;
  endtask

  task automatic wait_vsync_rise();
    @(negedge clk_sys_36_864);
    while (vsync !== 1'b0) @(negedge clk_sys_36_864);
    while (vsync !== 1'b1) @(negedge clk_sys_36_864);
  endtask

  task automatic wait_vblank_fall();
    @(negedge clk_sys_36_864);
    while (vblank !== 1'b1) @(negedge clk_sys_36_864);
    while (vblank !== 1'b0) @(negedge clk_sys_36_864);
  endtask

  // Every active sample of one frame must show the same colour
  task automatic check_frame(input logic [7:0] exp_r, input logic [7:0] exp_g,
                             input logic [7:0] exp_b);
    int samples;
    samples = 0;
    wait_vblank_fall();
    while (vblank === 1'b0) begin
      if (hblank === 1'b0) begin
        check("video_r", video_r, exp_r);
        check("video_g", video_g, exp_g);
        check("video_b", video_b, exp_b);
        samples++;
      end
      @(negedge clk_sys_36_864);
    end
    check("active video samples", samples, frame_samples);
  endtask

  task automatic test_reset_values();
    @(negedge clk_sys_36_864);
    check("hblank", hblank, 1);
    check("vblank", vblank, 1);
    check("hsync", hsync, 0);
    check("vsync", vsync, 0);
    check("video_r", video_r, 0);
    check("video_g", video_g, 0);
    check("video_b", video_b, 0);
    check("ff_active", ff_active, 0);
  endtask

  task automatic test_timing();
    int   lines;
    int   low_run;
    int   since_hs;
    logic prev_hb;
    logic prev_hs;
    lines = 0;
    low_run = 0;
    since_hs = -1;
    wait_vblank_fall();
    prev_hb = hblank;
    prev_hs = hsync;
    while (vblank === 1'b0) begin
      @(negedge clk_sys_36_864);
      if (since_hs >= 0) since_hs++;
      if (hblank === 1'b0) low_run++;
      if (prev_hb && !hblank) lines++;
      if (!prev_hb && hblank) begin
        check("hblank low clocks", low_run, active_clocks);
        low_run = 0;
      end
      if (!prev_hs && hsync) begin
        if (since_hs >= 0) check("hsync period", since_hs, line_clocks);
        since_hs = 0;
      end
      prev_hb = hblank;
      prev_hs = hsync;
    end
    check("lines with vblank low", lines, swan_video_pkg::screen_h);
  endtask

  task automatic test_single_buffer();
    swan_video_pkg::pixel_word_t c;
    c.raw = 12'($urandom);
    write_frame(c);
    wait_vsync_rise();
    check_frame(level_single(c.rgb.r), level_single(c.rgb.g), level_single(c.rgb.b));
  endtask

  task automatic test_two_frame_blend();
    swan_video_pkg::pixel_word_t a;
    swan_video_pkg::pixel_word_t b;
    a.raw = 12'($urandom);
    b.raw = 12'($urandom);
    @(posedge clk_sys_36_864);
    triple_buffer <= 1'b1;
    blend_mode    <= swan_video_pkg::blend_two;
    // One frame end after each write, so B is current and A is last
    write_frame(a);
    wait_vsync_rise();
    write_frame(b);
    wait_vsync_rise();
    check_frame(level_pair(b.rgb.r, a.rgb.r), level_pair(b.rgb.g, a.rgb.g),
                level_pair(b.rgb.b, a.rgb.b));
  endtask

  task automatic test_three_frame_blend();
    swan_video_pkg::pixel_word_t a;
    swan_video_pkg::pixel_word_t b;
    swan_video_pkg::pixel_word_t c;
    a.raw = 12'($urandom);
    b.raw = 12'($urandom);
    c.raw = 12'($urandom);
    @(posedge clk_sys_36_864);
    blend_mode <= swan_video_pkg::blend_three;
    write_frame(a);
    write_frame(b);
    write_frame(c);
    wait_vsync_rise();
    check_frame(level_triple(a.rgb.r, b.rgb.r, c.rgb.r),
                level_triple(a.rgb.g, b.rgb.g, c.rgb.g),
                level_triple(a.rgb.b, b.rgb.b, c.rgb.b));
  endtask

  task automatic check_audio(input logic muted);
    check("audio_l", audio_l, muted ? 16'h0 : audio_in_l);
    check("audio_r", audio_r, muted ? 16'h0 : audio_in_r);
  endtask

  // Holds select for the given cycles, then leaves three cycles to settle
  task automatic press_select(input int cycles);
    @(posedge clk_sys_36_864);
    button_select <= 1'b1;
    repeat (2) @(posedge clk_sys_36_864);
    @(negedge clk_sys_36_864);
    check("ff_active", ff_active, 1);
    check_audio(1'b1);
    repeat (cycles - 2) @(posedge clk_sys_36_864);
    button_select <= 1'b0;
    repeat (3) @(posedge clk_sys_36_864);
    @(negedge clk_sys_36_864);
  endtask

  task automatic test_fast_forward();
    press_select(10);
    check("ff_active", ff_active, 1);
    check_audio(1'b1);
    @(posedge clk_sys_36_864);
    ff_sound <= 1'b1;
    @(negedge clk_sys_36_864);
    check_audio(1'b0);
    @(posedge clk_sys_36_864);
    ff_sound <= 1'b0;
    // Second tap drops the latch
    press_select(10);
    check("ff_active", ff_active, 0);
    check_audio(1'b0);
    press_select(100);
    check("ff_active", ff_active, 0);
    check_audio(1'b0);
  endtask

  initial begin
    void'($urandom(18));
    rst_n         = 1'b0;
    pixel_we      = 1'b0;
    pixel_addr    = '0;
    pixel_data    = '0;
    triple_buffer = 1'b0;
    blend_mode    = swan_video_pkg::blend_off;
    button_select = 1'b0;
    ff_sound      = 1'b0;
    audio_in_l    = 16'($urandom) | 16'h0001;
    audio_in_r    = 16'($urandom) | 16'h0001;
    repeat (3) @(posedge clk_sys_36_864);
    rst_n <= 1'b1;
    test_reset_values();
    test_timing();
    test_single_buffer();
    test_two_frame_blend();
    test_three_frame_blend();
    test_fast_forward();
    $display("No errors");
    $finish;
  end

endmodule

/* bench/tb_swan_video_out_properties.sv */
module tb_swan_video_out_properties #(
  parameter int pix_div = 6
) (
  input logic        clk_sys_36_864,
  input logic        rst_n,
  input logic        hsync,
  input logic        vsync,
  input logic        vblank,
  input logic        ff_active,
  input logic        ff_sound,
  input logic [15:0] audio_l
);

  localparam int hs_cycles = (swan_video_pkg::hs_end - swan_video_pkg::hs_start) * pix_div;

  logic [15:0] hs_len;

  // Clocks spent high in the current hsync pulse
  always_ff @(posedge clk_sys_36_864 or negedge rst_n) begin
    if (!rst_n) begin
      hs_len <= '0;
    end else if (hsync) begin
      hs_len <= hs_len + 16'd1;
    end else begin
      hs_len <= '0;
    end
  end

  a_vsync_in_vblank : assert property (
    @(posedge clk_sys_36_864) disable iff (!rst_n) vsync |-> vblank
  ) else $error("vsync high outside vertical blank");

  a_hsync_width : assert property (
    @(posedge clk_sys_36_864) disable iff (!rst_n) $fell(hsync) |-> (hs_len == 16'(hs_cycles))
  ) else $error("hsync pulse lasted %0d clocks", hs_len);

  a_audio_mute : assert property (
    @(posedge clk_sys_36_864) disable iff (!rst_n) (ff_active && !ff_sound) |-> (audio_l == '0)
  ) else $error("audio_l not muted during fast forward");

endmodule

bind swan_video_out tb_swan_video_out_properties #(
  .pix_div (pix_div)
) i_tb_swan_video_out_properties (
  .clk_sys_36_864 (clk_sys_36_864),
  .rst_n          (rst_n),
  .hsync          (hsync),
  .vsync          (vsync),
  .vblank         (vblank),
  .ff_active      (ff_active),
  .ff_sound       (ff_sound),
  .audio_l        (audio_l)
);

/* hw/fast_forward.sv */
module fast_forward #(
  parameter int ff_tap_cycles = 6400000
) (
  input  logic        clk_sys_36_864,
  input  logic        rst_n,
  input  logic        button_select,
  input  logic        ff_sound,
  input  logic [15:0] audio_in_l,
  input  logic [15:0] audio_in_r,
  output logic        ff_active,
  output logic [15:0] audio_l,
  output logic [15:0] audio_r
);

  localparam int cnt_w = $clog2(ff_tap_cycles + 1);

  logic             btn_q;
  logic             ff_latch;
  logic             tap_set;
  logic [cnt_w-1:0] hold_cnt;

  always_ff @(posedge clk_sys_36_864 or negedge rst_n) begin
    if (!rst_n) begin
      btn_q     <= 1'b0;
      ff_latch  <= 1'b0;
      tap_set   <= 1'b0;
      hold_cnt  <= '0;
      ff_active <= 1'b0;
    end else begin
      btn_q <= button_select;
      // Saturates so a very long hold never looks like a tap
      if (button_select && (hold_cnt != cnt_w'(ff_tap_cycles))) begin
        hold_cnt <= hold_cnt + 1'b1;
      end
      if (button_select && !btn_q) begin
        ff_latch <= 1'b0;
        hold_cnt <= '0;
      end
      if (!button_select && btn_q) begin
        tap_set <= 1'b0;
        // Short tap toggles the latch on every other press
        if ((hold_cnt < cnt_w'(ff_tap_cycles)) && !tap_set) begin
          tap_set  <= 1'b1;
          ff_latch <= 1'b1;
        end
      end
      ff_active <= button_select | ff_latch;
    end
  end

  assign audio_l = (ff_active && !ff_sound) ? '0 : audio_in_l;
  assign audio_r = (ff_active && !ff_sound) ? '0 : audio_in_r;

endmodule

/* hw/flicker_blend.sv */
module flicker_blend (
  input  logic                        clk_sys_36_864,
  input  logic                        rst_n,
  input  logic                        pix_load,
  input  swan_video_pkg::blend_mode_t blend_mode,
  input  swan_video_pkg::pixel_word_t bank0_q,
  input  swan_video_pkg::pixel_word_t bank1_q,
  input  swan_video_pkg::pixel_word_t bank2_q,
  input  swan_video_pkg::bank_idx_t   cur_bank,
  input  swan_video_pkg::bank_idx_t   last_bank,
  output logic [7:0]                  video_r,
  output logic [7:0]                  video_g,
  output logic [7:0]                  video_b
);

  swan_video_pkg::pixel_word_t rgb_now;
  swan_video_pkg::pixel_word_t rgb_last;

  function automatic swan_video_pkg::pixel_word_t pick_bank(swan_video_pkg::bank_idx_t idx);
    case (idx)
      2'd0:    return bank0_q;
      2'd1:    return bank1_q;
      default: return bank2_q;
    endcase
  endfunction

  // One colour channel, nibbles in and an 8-bit level out
  function automatic logic [7:0] blend_chan(input logic [3:0] now, input logic [3:0] last,
                                            input logic [3:0] c0, input logic [3:0] c1,
                                            input logic [3:0] c2);
    logic [4:0]  sum2;
    logic [5:0]  sum3;
    logic [7:0]  level3;
    logic [23:0] scaled;
    sum2   = 5'(now) + 5'(last);
    sum3   = 6'(c0) + 6'(c1) + 6'(c2);
    level3 = {sum3, sum3[5:4]};
    scaled = (24'(level3) * 24'(swan_video_pkg::blend_mul)) / 24'(swan_video_pkg::blend_div);
    case (blend_mode)
      swan_video_pkg::blend_off: return {now, now};
      swan_video_pkg::blend_two: return {sum2, sum2[4:2]};
      default:                   return scaled[7:0];
    endcase
  endfunction

  always_comb begin
    rgb_now  = pick_bank(cur_bank);
    rgb_last = pick_bank(last_bank);
  end

  always_ff @(posedge clk_sys_36_864 or negedge rst_n) begin
    if (!rst_n) begin
      video_r <= '0;
      video_g <= '0;
      video_b <= '0;
    end else if (pix_load) begin
      video_r <= blend_chan(rgb_now.rgb.r, rgb_last.rgb.r,
                            bank0_q.rgb.r, bank1_q.rgb.r, bank2_q.rgb.r);
      video_g <= blend_chan(rgb_now.rgb.g, rgb_last.rgb.g,
                            bank0_q.rgb.g, bank1_q.rgb.g, bank2_q.rgb.g);
      video_b <= blend_chan(rgb_now.rgb.b, rgb_last.rgb.b,
                            bank0_q.rgb.b, bank1_q.rgb.b, bank2_q.rgb.b);
    end
  end

endmodule

/* hw/frame_buffer.sv */
module frame_buffer (
  input  logic                                  clk_sys_36_864,
  input  logic                                  rst_n,
  input  logic                                  pixel_we,
  input  logic [swan_video_pkg::pix_addr_w-1:0] pixel_addr,
  input  swan_video_pkg::pixel_word_t           pixel_data,
  input  logic                                  buffering,
  input  logic                                  frame_end,
  input  logic [swan_video_pkg::pix_addr_w-1:0] rd_addr,
  output swan_video_pkg::pixel_word_t           bank0_q,
  output swan_video_pkg::pixel_word_t           bank1_q,
  output swan_video_pkg::pixel_word_t           bank2_q,
  output swan_video_pkg::bank_idx_t             cur_bank,
  output swan_video_pkg::bank_idx_t             last_bank
);

  localparam logic [swan_video_pkg::pix_addr_w-1:0] last_addr =
    swan_video_pkg::pix_addr_w'(swan_video_pkg::frame_pixels - 1);

  swan_video_pkg::bank_idx_t wr_bank;
  swan_video_pkg::bank_idx_t next_bank;

  logic [11:0] bank_q [3];

  logic frame_done;

  // Core just wrote the last pixel of its frame
  assign frame_done = pixel_we && (pixel_addr == last_addr);

  // Write side rotation
  always_ff @(posedge clk_sys_36_864 or negedge rst_n) begin
    if (!rst_n) begin
      wr_bank   <= '0;
      next_bank <= '0;
    end else if (!buffering) begin
      wr_bank   <= '0;
      next_bank <= '0;
    end else if (frame_done) begin
      // Finished bank becomes the one to show next
      next_bank <= wr_bank;
      if (wr_bank == 2'd2) begin
        wr_bank <= '0;
      end else begin
        wr_bank <= wr_bank + 2'd1;
      end
    end
  end

  // Display side only swaps at the end of a scanned frame
  always_ff @(posedge clk_sys_36_864 or negedge rst_n) begin
    if (!rst_n) begin
      cur_bank  <= '0;
      last_bank <= '0;
    end else if (frame_end) begin
      cur_bank  <= next_bank;
      last_bank <= cur_bank;
    end
  end

  for (genvar i = 0; i < 3; i++) begin : g_bank
    logic [11:0] mem [swan_video_pkg::frame_pixels];

    always_ff @(posedge clk_sys_36_864) begin
      if (pixel_we && (wr_bank == swan_video_pkg::bank_idx_t'(i))) begin
        mem[pixel_addr] <= pixel_data.raw;
      end
      // All banks read together so the blend can see every frame
      bank_q[i] <= mem[rd_addr];
    end
  end

  assign bank0_q = bank_q[0];
  assign bank1_q = bank_q[1];
  assign bank2_q = bank_q[2];

endmodule

/* hw/swan_video_out.sv */
module swan_video_out #(
  parameter int pix_div       = 6,
  parameter int ff_tap_cycles = 6400000
) (
  input  logic                                  clk_sys_36_864,
  input  logic                                  rst_n,
  input  logic                                  pixel_we,
  input  logic [swan_video_pkg::pix_addr_w-1:0] pixel_addr,
  input  swan_video_pkg::pixel_word_t           pixel_data,
  input  logic                                  triple_buffer,
  input  swan_video_pkg::blend_mode_t           blend_mode,
  input  logic                                  button_select,
  input  logic                                  ff_sound,
  input  logic [15:0]                           audio_in_l,
  input  logic [15:0]                           audio_in_r,
  output logic                                  hsync,
  output logic                                  vsync,
  output logic                                  hblank,
  output logic                                  vblank,
  output logic [7:0]                            video_r,
  output logic [7:0]                            video_g,
  output logic [7:0]                            video_b,
  output logic                                  ff_active,
  output logic [15:0]                           audio_l,
  output logic [15:0]                           audio_r
);

  logic                                  buffering;
  logic                                  frame_end;
  logic                                  pix_load;
  logic [swan_video_pkg::pix_addr_w-1:0] rd_addr;
  swan_video_pkg::pixel_word_t           bank0_q;
  swan_video_pkg::pixel_word_t           bank1_q;
  swan_video_pkg::pixel_word_t           bank2_q;
  swan_video_pkg::bank_idx_t             cur_bank;
  swan_video_pkg::bank_idx_t             last_bank;

  // Three-frame blend needs every bank, so it forces rotation on
  assign buffering = triple_buffer || (blend_mode == swan_video_pkg::blend_three);

  frame_buffer i_frame_buffer (
    .clk_sys_36_864 (clk_sys_36_864),
    .rst_n          (rst_n),
    .pixel_we       (pixel_we),
    .pixel_addr     (pixel_addr),
    .pixel_data     (pixel_data),
    .buffering      (buffering),
    .frame_end      (frame_end),
    .rd_addr        (rd_addr),
    .bank0_q        (bank0_q),
    .bank1_q        (bank1_q),
    .bank2_q        (bank2_q),
    .cur_bank       (cur_bank),
    .last_bank      (last_bank)
  );

  video_timing #(
    .pix_div (pix_div)
  ) i_video_timing (
    .clk_sys_36_864 (clk_sys_36_864),
    .rst_n          (rst_n),
    .pix_load       (pix_load),
    .hsync          (hsync),
    .vsync          (vsync),
    .hblank         (hblank),
    .vblank         (vblank),
    .frame_end      (frame_end),
    .rd_addr        (rd_addr)
  );

  flicker_blend i_flicker_blend (
    .clk_sys_36_864 (clk_sys_36_864),
    .rst_n          (rst_n),
    .pix_load       (pix_load),
    .blend_mode     (blend_mode),
    .bank0_q        (bank0_q),
    .bank1_q        (bank1_q),
    .bank2_q        (bank2_q),
    .cur_bank       (cur_bank),
    .last_bank      (last_bank),
    .video_r        (video_r),
    .video_g        (video_g),
    .video_b        (video_b)
  );

  fast_forward #(
    .ff_tap_cycles (ff_tap_cycles)
  ) i_fast_forward (
    .clk_sys_36_864 (clk_sys_36_864),
    .rst_n          (rst_n),
    .button_select  (button_select),
    .ff_sound       (ff_sound),
    .audio_in_l     (audio_in_l),
    .audio_in_r     (audio_in_r),
    .ff_active      (ff_active),
    .audio_l        (audio_l),
    .audio_r        (audio_r)
  );

endmodule

/* hw/swan_video_pkg.sv */
package swan_video_pkg;

  // Visible screen geometry
  localparam int screen_w = 224;
  localparam int screen_h = 144;

  // One bank holds a full visible frame
  localparam int frame_pixels = screen_w * screen_h;
  localparam int pix_addr_w = 15;

  // Beam counter limits, 401 ticks per line and 258 lines per frame
  localparam int h_last = 400;
  localparam int v_last = 257;

  // Horizontal blank window
  localparam int hbl_end = 31;
  localparam int hbl_start = hbl_end + screen_w;

  // Vertical blank window
  localparam int vbl_end = 66;
  localparam int vbl_start = vbl_end + screen_h;

  // Sync placement in pixel ticks and lines
  localparam int hs_start = 320;
  localparam int hs_end = 352;
  localparam int vs_line_on = 1;
  localparam int vs_line_off = 4;

  // Three-frame average, roughly x * 4/3 / 4 to stretch 6 bits up to 8
  localparam int blend_mul = 21845;
  localparam int blend_div = 16384;

  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } pixel_rgb_t;

  // Raw word for memory, nibbles for the blend math
  typedef union packed {
    logic [11:0] raw;
    pixel_rgb_t  rgb;
  } pixel_word_t;

  typedef enum logic [1:0] {
    blend_off   = 2'd0,
    blend_two   = 2'd1,
    blend_three = 2'd2
  } blend_mode_t;

  // Bank number, 0 to 2
  typedef logic [1:0] bank_idx_t;

endpackage

/* hw/video_timing.sv */
module video_timing #(
  parameter int pix_div = 6
) (
  input  logic                                  clk_sys_36_864,
  input  logic                                  rst_n,
  output logic                                  pix_load,
  output logic                                  hsync,
  output logic                                  vsync,
  output logic                                  hblank,
  output logic                                  vblank,
  output logic                                  frame_end,
  output logic [swan_video_pkg::pix_addr_w-1:0] rd_addr
);

  localparam int div_w = (pix_div > 1) ? $clog2(pix_div) : 1;

  typedef logic [8:0] coord_t;

  logic [div_w-1:0] div_cnt;
  logic             pix_ce;
  coord_t           x;
  coord_t           y;
  logic             line_end;

  // Pixel clock divider
  always_ff @(posedge clk_sys_36_864 or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      pix_ce  <= 1'b0;
    end else begin
      if (div_cnt == div_w'(pix_div - 1)) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
      pix_ce <= (div_cnt == '0);
    end
  end

  assign pix_load = (div_cnt == '0);

  assign line_end = (x == coord_t'(swan_video_pkg::h_last));

  // Last tick of the last line
  assign frame_end = pix_ce && line_end && (y == coord_t'(swan_video_pkg::v_last));

  // Beam position
  always_ff @(posedge clk_sys_36_864 or negedge rst_n) begin
    if (!rst_n) begin
      x <= '0;
      y <= '0;
    end else if (pix_ce) begin
      if (line_end) begin
        x <= '0;
        if (y == coord_t'(swan_video_pkg::v_last)) begin
          y <= '0;
        end else begin
          y <= y + 1'b1;
        end
      end else begin
        x <= x + 1'b1;
      end
    end
  end

  // Blanks and syncs, evaluated on the divider-zero cycle
  always_ff @(posedge clk_sys_36_864 or negedge rst_n) begin
    if (!rst_n) begin
      hblank <= 1'b1;
      vblank <= 1'b1;
      hsync  <= 1'b0;
      vsync  <= 1'b0;
    end else if (pix_load) begin
      if (x == coord_t'(swan_video_pkg::hbl_start)) begin
        hblank <= 1'b1;
      end
      if (x == coord_t'(swan_video_pkg::hbl_end)) begin
        hblank <= 1'b0;
      end
      if (y == coord_t'(swan_video_pkg::vbl_end)) begin
        vblank <= 1'b0;
      end
      if (y >= coord_t'(swan_video_pkg::vbl_start)) begin
        vblank <= 1'b1;
      end
      if (x == coord_t'(swan_video_pkg::hs_start)) begin
        hsync <= 1'b1;
        // vsync edges line up with the start of hsync
        if (y == coord_t'(swan_video_pkg::vs_line_on)) begin
          vsync <= 1'b1;
        end
        if (y == coord_t'(swan_video_pkg::vs_line_off)) begin
          vsync <= 1'b0;
        end
      end
      if (x == coord_t'(swan_video_pkg::hs_end)) begin
        hsync <= 1'b0;
      end
    end
  end

  // Frame read address walks the visible area only
  always_ff @(posedge clk_sys_36_864 or negedge rst_n) begin
    if (!rst_n) begin
      rd_addr <= '0;
    end else if (pix_ce) begin
      if (vblank) begin
        rd_addr <= '0;
      end else if (!hblank) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

endmodule

/* vlog.f */
hw/swan_video_pkg.sv
hw/frame_buffer.sv
hw/video_timing.sv
hw/flicker_blend.sv
hw/fast_forward.sv
hw/swan_video_out.sv
bench/tb_swan_video_out_properties.sv
bench/tb_swan_video_out.sv
